//--- Bender.yml
package:
  name: dram_traffic

sources:
  - files:
      - dram_traffic_pkg.sv
      - dram_request_issuer.sv
      - dram_inflight_queue.sv
      - dram_response_router.sv
      - dram_traffic_top.sv
  - target: test
    files:
      - tb_dram_model.sv
      - tb_dram_traffic_top.sv

//--- dram_inflight_queue.sv
`timescale 1ns/1ps

module dram_inflight_queue
    import dram_traffic_pkg::*;
(
    input  logic      clk_dram_ctrl,
    input  logic      rst_dram_ctrl,

    // from issuer, one record per request taken
    input  logic      i_push,
    input  inflight_t i_push_entry,

    // from router, on retire
    input  logic      i_pop,

    output inflight_t o_head,
    output logic      o_empty,
    output logic      o_full
);

    inflight_t  entries [INFLIGHT_DEPTH];
    queue_ptr_t wr_ptr;
    queue_ptr_t rd_ptr;
    logic       do_push;
    logic       do_pop;

    // same index with wrap bits differing means full
    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[QUEUE_IDX_W] != rd_ptr[QUEUE_IDX_W]) &&
                     (wr_ptr[QUEUE_IDX_W-1:0] == rd_ptr[QUEUE_IDX_W-1:0]);

    // guard against misuse at the edges
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    // oldest unretired request
    assign o_head = entries[rd_ptr[QUEUE_IDX_W-1:0]];

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage itself
    always_ff @(posedge clk_dram_ctrl) begin
        if (do_push) begin
            entries[wr_ptr[QUEUE_IDX_W-1:0]] <= i_push_entry;
        end
    end

endmodule

//--- dram_request_issuer.sv
`timescale 1ns/1ps

module dram_request_issuer
    import dram_traffic_pkg::*;
(
    input  logic          clk_dram_ctrl,
    input  logic          rst_dram_ctrl,

    // sample load stream
    input  wr_beat_t      i_wr,
    input  logic          i_wr_valid,
    output logic          o_wr_ready,

    // playback address stream
    input  dram_addr_t    i_rd_addr,
    input  logic          i_rd_valid,
    output logic          o_rd_ready,

    input  logic          i_load_complete,

    // controller request port
    output mem_req_t      o_mem_req,
    output logic          o_mem_stb,
    input  logic          i_mem_busy,

    // in-flight queue
    output logic          o_push,
    output inflight_t     o_push_entry,
    input  logic          i_queue_full
);

    issuer_state_t state;
    dram_addr_t    wr_addr;
    logic          wr_accept;
    logic          rd_accept;
    logic          taken;

    // no new beat while one is parked on the port
    // queue full means the outstanding limit is reached
    assign o_wr_ready = (state == ST_LOAD) && !i_load_complete && !i_queue_full;
    assign o_rd_ready = (state == ST_PLAY) && !i_queue_full;

    assign wr_accept = i_wr_valid && o_wr_ready;
    assign rd_accept = i_rd_valid && o_rd_ready;

    // strobe is just the hold state decoded
    assign o_mem_stb = (state == ST_HOLD);
    // controller takes the request when not stalling
    assign taken     = o_mem_stb && !i_mem_busy;
    // record goes into the queue on the same cycle
    assign o_push    = taken;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            state   <= ST_LOAD;
            wr_addr <= '0;
        end else begin
            case (state)
                ST_LOAD: begin
                    if (wr_accept) begin
                        state <= ST_HOLD;
                    end else if (i_load_complete) begin
                        // last write acked, switch to playback
                        state <= ST_PLAY;
                    end
                end
                ST_PLAY: begin
                    if (rd_accept) begin
                        state <= ST_HOLD;
                    end
                end
                ST_HOLD: begin
                    // back to whichever phase is current
                    if (taken) begin
                        state <= i_load_complete ? ST_PLAY : ST_LOAD;
                    end
                end
                default: begin
                    state <= ST_LOAD;
                end
            endcase

            // samples land at consecutive bursts from zero
            if (taken && o_mem_req.we) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // request and queue record built at accept, frozen while stalled
    always_ff @(posedge clk_dram_ctrl) begin
        if (wr_accept) begin
            o_mem_req.we         <= 1'b1;
            o_mem_req.addr       <= wr_addr;
            o_mem_req.wdata      <= i_wr.data;
            o_push_entry.is_read <= 1'b0;
            o_push_entry.last    <= i_wr.last;
            o_push_entry.addr    <= wr_addr;
        end else if (rd_accept) begin
            o_mem_req.we         <= 1'b0;
            o_mem_req.addr       <= i_rd_addr;
            // write data unused on reads
            o_mem_req.wdata      <= '0;
            o_push_entry.is_read <= 1'b1;
            o_push_entry.last    <= 1'b0;
            o_push_entry.addr    <= i_rd_addr;
        end
    end

endmodule

//--- dram_response_router.sv
`timescale 1ns/1ps

module dram_response_router
    import dram_traffic_pkg::*;
(
    input  logic         clk_dram_ctrl,
    input  logic         rst_dram_ctrl,

    // controller response
    input  logic         i_mem_ack,
    input  dram_data_t   i_mem_rdata,

    // queue head
    input  inflight_t    i_head,
    input  logic         i_empty,
    output logic         o_pop,

    // audio response stream
    output audio_resp_t  o_audio,
    output logic         o_audio_valid,
    input  logic         i_audio_ready,

    output logic         o_sample_load_complete,

    // debug display
    output ack_count_t   o_ack_count,
    output audio_count_t o_audio_count
);

    dram_data_t rdata_mem [INFLIGHT_DEPTH];
    queue_ptr_t rdata_wr_ptr;
    queue_ptr_t rdata_rd_ptr;
    logic       ack_write;
    logic       ack_read;
    logic       audio_taken;

    // queue never mixes writes and reads
    // so the head kind is the kind of whatever just acked
    assign ack_write = i_mem_ack && !i_empty && !i_head.is_read;
    assign ack_read  = i_mem_ack && !i_empty && i_head.is_read;

    // word is there the cycle after its ack
    assign o_audio_valid = (rdata_wr_ptr != rdata_rd_ptr);
    assign audio_taken   = o_audio_valid && i_audio_ready;

    // read data retires in order, so head addr matches oldest word
    assign o_audio.addr = i_head.addr;
    assign o_audio.data = rdata_mem[rdata_rd_ptr[QUEUE_IDX_W-1:0]];

    // writes retire at ack, reads once delivered
    assign o_pop = ack_write || audio_taken;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            rdata_wr_ptr <= '0;
            rdata_rd_ptr <= '0;
        end else begin
            // no overflow check, depth matches the queue
            if (ack_read) begin
                rdata_wr_ptr <= rdata_wr_ptr + 1'b1;
            end
            if (audio_taken) begin
                rdata_rd_ptr <= rdata_rd_ptr + 1'b1;
            end
        end
    end

    // captured read words
    always_ff @(posedge clk_dram_ctrl) begin
        if (ack_read) begin
            rdata_mem[rdata_wr_ptr[QUEUE_IDX_W-1:0]] <= i_mem_rdata;
        end
    end

    // sticky until reset
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_sample_load_complete <= 1'b0;
        end else if (ack_write && i_head.last) begin
            o_sample_load_complete <= 1'b1;
        end
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_ack_count   <= '0;
            o_audio_count <= '0;
        end else begin
            // every completed request, reads and writes
            if (i_mem_ack) begin
                o_ack_count <= o_ack_count + 1'b1;
            end
            // only words actually handed downstream
            if (audio_taken) begin
                o_audio_count <= o_audio_count + 1'b1;
            end
        end
    end

endmodule

//--- dram_traffic_pkg.sv
package dram_traffic_pkg;

    // controller port widths
    localparam int DRAM_ADDR_W = 24;
    localparam int DRAM_DATA_W = 128;

    // debug counter widths
    localparam int ACK_COUNT_W   = 24;
    localparam int AUDIO_COUNT_W = 16;

    // max requests outstanding at once
    localparam int INFLIGHT_DEPTH = 4;
    localparam int QUEUE_IDX_W    = $clog2(INFLIGHT_DEPTH);
    // extra msb tells full from empty
    localparam int QUEUE_PTR_W    = QUEUE_IDX_W + 1;

    // burst address, {row, bank, col}
    typedef logic [DRAM_ADDR_W-1:0]   dram_addr_t;
    typedef logic [DRAM_DATA_W-1:0]   dram_data_t;
    typedef logic [ACK_COUNT_W-1:0]   ack_count_t;
    typedef logic [AUDIO_COUNT_W-1:0] audio_count_t;
    typedef logic [QUEUE_PTR_W-1:0]   queue_ptr_t;

    // one beat of the sample load stream
    typedef struct packed {
        dram_data_t data;
        logic       last;
    } wr_beat_t;

    // request as seen by the controller port
    typedef struct packed {
        logic       we;
        dram_addr_t addr;
        dram_data_t wdata;
    } mem_req_t;

    // bookkeeping for a request awaiting its ack
    typedef struct packed {
        logic       is_read;
        logic       last;
        dram_addr_t addr;
    } inflight_t;

    // audio word paired with where it came from
    typedef struct packed {
        dram_addr_t addr;
        dram_data_t data;
    } audio_resp_t;

    typedef enum logic [1:0] {
        ST_LOAD,
        ST_PLAY,
        ST_HOLD
    } issuer_state_t;

endpackage

//--- dram_traffic_top.f
dram_traffic_pkg.sv
dram_request_issuer.sv
dram_inflight_queue.sv
dram_response_router.sv
dram_traffic_top.sv
tb_dram_model.sv
tb_dram_traffic_top.sv

//--- dram_traffic_top.sv
`timescale 1ns/1ps

module dram_traffic_top
    import dram_traffic_pkg::*;
(
    input  logic         clk_dram_ctrl,
    input  logic         rst_dram_ctrl,

    // sample load stream
    input  wr_beat_t     i_wr,
    input  logic         i_wr_valid,
    output logic         o_wr_ready,

    // playback address stream
    input  dram_addr_t   i_rd_addr,
    input  logic         i_rd_valid,
    output logic         o_rd_ready,

    // controller port, stb/stall/ack
    output mem_req_t     o_mem_req,
    output logic         o_mem_stb,
    input  logic         i_mem_busy,
    input  logic         i_mem_ack,
    input  dram_data_t   i_mem_rdata,

    // audio response stream
    output audio_resp_t  o_audio,
    output logic         o_audio_valid,
    input  logic         i_audio_ready,

    output logic         o_sample_load_complete,
    output ack_count_t   o_ack_count,
    output audio_count_t o_audio_count
);

    logic      push;
    inflight_t push_entry;
    logic      pop;
    inflight_t head;
    logic      queue_empty;
    logic      queue_full;

    dram_request_issuer dram_request_issuer_i (
        .clk_dram_ctrl   (clk_dram_ctrl),
        .rst_dram_ctrl   (rst_dram_ctrl),
        .i_wr            (i_wr),
        .i_wr_valid      (i_wr_valid),
        .o_wr_ready      (o_wr_ready),
        .i_rd_addr       (i_rd_addr),
        .i_rd_valid      (i_rd_valid),
        .o_rd_ready      (o_rd_ready),
        // phase switch comes back from the router
        .i_load_complete (o_sample_load_complete),
        .o_mem_req       (o_mem_req),
        .o_mem_stb       (o_mem_stb),
        .i_mem_busy      (i_mem_busy),
        .o_push          (push),
        .o_push_entry    (push_entry),
        .i_queue_full    (queue_full)
    );

    dram_inflight_queue dram_inflight_queue_i (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_push        (push),
        .i_push_entry  (push_entry),
        .i_pop         (pop),
        .o_head        (head),
        .o_empty       (queue_empty),
        .o_full        (queue_full)
    );

    dram_response_router dram_response_router_i (
        .clk_dram_ctrl          (clk_dram_ctrl),
        .rst_dram_ctrl          (rst_dram_ctrl),
        .i_mem_ack              (i_mem_ack),
        .i_mem_rdata            (i_mem_rdata),
        .i_head                 (head),
        .i_empty                (queue_empty),
        .o_pop                  (pop),
        .o_audio                (o_audio),
        .o_audio_valid          (o_audio_valid),
        .i_audio_ready          (i_audio_ready),
        .o_sample_load_complete (o_sample_load_complete),
        .o_ack_count            (o_ack_count),
        .o_audio_count          (o_audio_count)
    );

endmodule

//--- tb_dram_model.sv
`timescale 1ns/1ps

module tb_dram_model
    import dram_traffic_pkg::*;
(
    input  logic       clk_dram_ctrl,
    input  logic       i_long_stalls,
    input  mem_req_t   i_mem_req,
    input  logic       i_mem_stb,
    output logic       o_mem_busy,
    output logic       o_mem_ack,
    output dram_data_t o_mem_rdata,
    output int         o_error_count
);

    // taken request waiting for its ack
    typedef struct packed {
        logic [31:0] due;
        logic        is_read;
        dram_addr_t  addr;
    } pending_t;

    dram_data_t  mem [dram_addr_t];
    pending_t    pending [$];
    pending_t    acked;
    logic [31:0] cycle = 0;
    logic [31:0] last_due = 0;
    int          stall_left = 0;
    int          errors = 0;
    integer      seed = 32'ha662;
    logic        long_mode;
    logic        held = 1'b0;
    mem_req_t    held_req;

    assign o_error_count = errors;

    // port driver, 1 ns after each edge
    initial begin
        o_mem_busy  = 1'b0;
        o_mem_ack   = 1'b0;
        o_mem_rdata = '0;
        forever begin
            @(posedge clk_dram_ctrl);
            cycle = cycle + 1;
            long_mode = i_long_stalls;
            #1;
            if (stall_left > 0) begin
                stall_left = stall_left - 1;
                o_mem_busy = 1'b1;
            end else if (long_mode && ($random(seed) & 1)) begin
                // long stall, 1 to 8 cycles
                stall_left = {$random(seed)} % 8;
                o_mem_busy = 1'b1;
            end else begin
                o_mem_busy = (($random(seed) & 3) == 0);
            end
            // acks strictly in issue order
            o_mem_ack = 1'b0;
            if (pending.size() > 0 && pending[0].due <= cycle) begin
                acked = pending.pop_front();
                o_mem_ack = 1'b1;
                o_mem_rdata = acked.is_read ? mem[acked.addr] : '0;
            end
        end
    end

    // observer, mid-cycle where the port is stable
    always @(negedge clk_dram_ctrl) begin : observe
        int lat;
        if (held) begin
            assert (i_mem_stb && i_mem_req == held_req) else begin
                $display("** Error: o_mem_req expected %0h actual %0h (o_mem_stb %0h)",
                         held_req, i_mem_req, i_mem_stb);
                errors = errors + 1;
            end
        end
        if (i_mem_stb && !o_mem_busy) begin
            if (i_mem_req.we) begin
                mem[i_mem_req.addr] = i_mem_req.wdata;
            end
            // latency 1 to 6, never ahead of an older ack
            lat = 1 + ({$random(seed)} % 6);
            last_due = (cycle + 1 + lat > last_due) ? cycle + 1 + lat : last_due + 1;
            pending.push_back({last_due, !i_mem_req.we, i_mem_req.addr});
            assert (pending.size() <= INFLIGHT_DEPTH) else begin
                $display("more than %0d requests outstanding at the memory port",
                         INFLIGHT_DEPTH);
                errors = errors + 1;
            end
        end
        if (o_mem_ack && acked.is_read) begin
            assert (mem.exists(acked.addr)) else begin
                $display("memory returned data that was never written at %0h", acked.addr);
                errors = errors + 1;
            end
        end
        held     = i_mem_stb && o_mem_busy;
        held_req = i_mem_req;
    end

endmodule

//--- tb_dram_traffic_top.sv
`timescale 1ns/1ps

module tb_dram_traffic_top
    import dram_traffic_pkg::*;
();

    localparam int N_LOAD          = 16;
    localparam int N_PLAY          = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int READY_LEN       = 1024;
    localparam int WATCHDOG_CYCLES = (N_LOAD + 2 * N_PLAY) * 20;

    logic         clk_dram_ctrl = 1'b0;
    logic         rst_dram_ctrl;
    wr_beat_t     wr;
    logic         wr_valid;
    logic         wr_ready;
    dram_addr_t   rd_addr;
    logic         rd_valid;
    logic         rd_ready;
    mem_req_t     mem_req;
    logic         mem_stb;
    logic         mem_busy;
    logic         mem_ack;
    dram_data_t   mem_rdata;
    audio_resp_t  audio;
    logic         audio_valid;
    logic         audio_ready;
    logic         load_complete;
    ack_count_t   ack_count;
    audio_count_t audio_count;
    logic         long_stalls;
    logic         random_ready;
    int           model_errors;

    integer       seed;
    dram_data_t   load_data [N_LOAD];
    logic         ready_bits [READY_LEN];
    int           ready_idx = 0;
    audio_resp_t  expected [$];
    logic         last_write_acked = 1'b0;
    int           acks_seen = 0;
    int           wr_taken = 0;
    int           rd_taken = 0;
    int           resp_taken = 0;
    int           errors = 0;
    int           errors_at_start = 0;
    int           tests_run = 0;
    int           tests_failed = 0;

    always #2 clk_dram_ctrl = ~clk_dram_ctrl;

    dram_traffic_top dram_traffic_top_i (
        .clk_dram_ctrl          (clk_dram_ctrl),
        .rst_dram_ctrl          (rst_dram_ctrl),
        .i_wr                   (wr),
        .i_wr_valid             (wr_valid),
        .o_wr_ready             (wr_ready),
        .i_rd_addr              (rd_addr),
        .i_rd_valid             (rd_valid),
        .o_rd_ready             (rd_ready),
        .o_mem_req              (mem_req),
        .o_mem_stb              (mem_stb),
        .i_mem_busy             (mem_busy),
        .i_mem_ack              (mem_ack),
        .i_mem_rdata            (mem_rdata),
        .o_audio                (audio),
        .o_audio_valid          (audio_valid),
        .i_audio_ready          (audio_ready),
        .o_sample_load_complete (load_complete),
        .o_ack_count            (ack_count),
        .o_audio_count          (audio_count)
    );

    tb_dram_model tb_dram_model_i (
        .clk_dram_ctrl (clk_dram_ctrl),
        .i_long_stalls (long_stalls),
        .i_mem_req     (mem_req),
        .i_mem_stb     (mem_stb),
        .o_mem_busy    (mem_busy),
        .o_mem_ack     (mem_ack),
        .o_mem_rdata   (mem_rdata),
        .o_error_count (model_errors)
    );

    task automatic expect_equal(input string name, input logic [159:0] exp,
                                input logic [159:0] act);
        assert (exp === act) else begin
            $display("** Error: %s expected %0h actual %0h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic finish_test(input string name);
        int found;
        found = errors + model_errors - errors_at_start;
        tests_run = tests_run + 1;
        if (found != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %s: %0d errors, %s", name, found, (found == 0) ? "ok" : "FAILED");
        errors_at_start = errors + model_errors;
    endtask

    // returns 1 ns after the edge that takes the beat
    task automatic send_write(input wr_beat_t beat);
        wr = beat;
        wr_valid = 1'b1;
        @(negedge clk_dram_ctrl);
        while (!wr_ready) begin
            @(negedge clk_dram_ctrl);
        end
        @(posedge clk_dram_ctrl);
        #1;
    endtask

    task automatic send_read(input dram_addr_t addr);
        rd_addr = addr;
        rd_valid = 1'b1;
        @(negedge clk_dram_ctrl);
        while (!rd_ready) begin
            @(negedge clk_dram_ctrl);
        end
        @(posedge clk_dram_ctrl);
        #1;
    endtask

    task automatic run_playback();
        int start;
        start = resp_taken;
        for (int n = 0; n < N_PLAY; n++) begin
            send_read(dram_addr_t'({$random(seed)} % N_LOAD));
        end
        rd_valid = 1'b0;
        // every address sent must come back as a response
        while (resp_taken - start < N_PLAY) begin
            @(posedge clk_dram_ctrl);
        end
        #1;
    endtask

    // audio ready, all high or from the pattern
    initial begin : drive_ready
        logic use_pattern;
        audio_ready = 1'b1;
        forever begin
            @(posedge clk_dram_ctrl);
            use_pattern = random_ready;
            #1;
            ready_idx = (ready_idx + 1) % READY_LEN;
            audio_ready = use_pattern ? ready_bits[ready_idx] : 1'b1;
        end
    end

    // scoreboard, sampled mid-cycle ahead of the edge
    always @(negedge clk_dram_ctrl) begin : monitor
        audio_resp_t exp_resp;
        if (!rst_dram_ctrl) begin
            // rises exactly one cycle after the last write ack
            expect_equal("o_sample_load_complete", last_write_acked, load_complete);
            // write beats only in the load phase with nothing parked on the port
            assert (!wr_ready || (!mem_stb && !load_complete)) else begin
                $display("o_wr_ready went high while a request was held or after the load");
                errors = errors + 1;
            end
            assert (!rd_ready || (!mem_stb && load_complete)) else begin
                $display("o_rd_ready went high while a request was held or before the load");
                errors = errors + 1;
            end
            if (mem_ack) begin
                acks_seen = acks_seen + 1;
                if (acks_seen == N_LOAD) begin
                    last_write_acked = 1'b1;
                end
            end
            if (mem_stb && !mem_busy && mem_req.we) begin
                if (wr_taken < N_LOAD) begin
                    expect_equal("o_mem_req.addr", wr_taken, mem_req.addr);
                    expect_equal("o_mem_req.wdata", load_data[wr_taken], mem_req.wdata);
                end else begin
                    $display("memory took more writes than beats were sent");
                    errors = errors + 1;
                end
                wr_taken = wr_taken + 1;
            end
            if (mem_stb && !mem_busy && !mem_req.we) begin
                rd_taken = rd_taken + 1;
            end
            if (audio_valid && audio_ready) begin
                resp_taken = resp_taken + 1;
                if (expected.size() == 0) begin
                    $display("audio response delivered with no read outstanding");
                    errors = errors + 1;
                end else begin
                    exp_resp = expected.pop_front();
                    expect_equal("o_audio.addr", exp_resp.addr, audio.addr);
                    expect_equal("o_audio.data", exp_resp.data, audio.data);
                end
            end
            if (rd_valid && rd_ready) begin
                expected.push_back({rd_addr, load_data[rd_addr]});
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_dram_ctrl);
        $display("watchdog expired after %0d cycles, a test never finished", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        wr_beat_t beat;
        seed = 32'ha662;
        rst_dram_ctrl = 1'b1;
        wr = '0;
        wr_valid = 1'b0;
        rd_addr = '0;
        rd_valid = 1'b0;
        long_stalls = 1'b0;
        random_ready = 1'b0;
        // ready held low for half of each 64 cycles, coin flips otherwise
        for (int k = 0; k < READY_LEN; k++) begin
            ready_bits[k] = (k % 64 < 32) ? 1'b0 : $random(seed) & 1;
        end
        for (int n = 0; n < N_LOAD; n++) begin
            load_data[n] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        repeat (RESET_CYCLES) @(posedge clk_dram_ctrl);
        #1;
        rst_dram_ctrl = 1'b0;

        @(negedge clk_dram_ctrl);
        expect_equal("o_mem_stb", 0, mem_stb);
        expect_equal("o_audio_valid", 0, audio_valid);
        expect_equal("o_sample_load_complete", 0, load_complete);
        expect_equal("o_rd_ready", 0, rd_ready);
        expect_equal("o_ack_count", 0, ack_count);
        expect_equal("o_audio_count", 0, audio_count);
        finish_test("reset");

        @(posedge clk_dram_ctrl);
        #1;
        for (int n = 0; n < N_LOAD; n++) begin
            beat.data = load_data[n];
            beat.last = (n == N_LOAD - 1);
            send_write(beat);
        end
        wr_valid = 1'b0;
        while (!load_complete) begin
            @(negedge clk_dram_ctrl);
        end
        @(posedge clk_dram_ctrl);
        #1;
        finish_test("load");

        run_playback();
        finish_test("playback");

        long_stalls = 1'b1;
        random_ready = 1'b1;
        run_playback();
        long_stalls = 1'b0;
        random_ready = 1'b0;
        finish_test("back-pressure");

        @(negedge clk_dram_ctrl);
        expect_equal("o_ack_count", wr_taken + rd_taken, ack_count);
        expect_equal("o_audio_count", resp_taken, audio_count);
        expect_equal("reads taken by memory", 2 * N_PLAY, rd_taken);
        assert (expected.size() == 0) else begin
            $display("%0d reads never produced an audio response", expected.size());
            errors = errors + 1;
        end
        finish_test("counters");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors + model_errors);
        if (tests_failed == 0 && errors + model_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
